/* core_top.f */
source/core_pkg.sv
source/bridge_settings.sv
source/slot_status.sv
source/video_conditioner.sv
source/core_top.sv
sim/tb_clock.sv
sim/core_top_tb.sv

/* sim/core_top_tb.sv */
// testbench for core_top, one pixel per clk_74a
// a reference model follows the driven inputs, assertions compare outputs
// random stimulus from $urandom with a fixed seed
// the run stops at a cycle limit of twice the expected stimulus length

`timescale 1ns/1ps

module core_top_tb import core_pkg::*; ();

  // longest raster is about 1900 cycles, bridge traffic runs alongside
  localparam int stim_cycles    = 2000;
  localparam int timeout_cycles = 2 * stim_cycles;

  logic           clk_74a;
  logic           pll_core_locked;
  bridge_wr_t     bridge;
  logic           dataslot_requestwrite;
  logic           dataslot_allcomplete;
  logic           has_save;
  video_in_t      video_in;
  core_settings_t settings;
  logic           download;
  datatable_wr_t  datatable;
  video_out_t     video_out;

  // reference model state
  core_settings_t exp_settings;
  logic           exp_download;
  datatable_wr_t  exp_table;
  video_out_t     exp_video;
  logic           prev_active;
  logic           prev_hs;
  logic           prev_vs;
  logic           model_active;
  logic [23:0]    model_slot;
  int             since_hs_rise;

  int error_count = 0;
  int cycle_count = 0;

  tb_clock tb_clock_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked)
  );

  core_top core_top_inst (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .bridge                (bridge),
    .settings              (settings),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .has_save              (has_save),
    .download              (download),
    .datatable             (datatable),
    .video_in              (video_in),
    .video_out             (video_out)
  );

  ////////////////////////////////////////////////////
  // reference model

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      exp_settings  <= '0;
      exp_download  <= 1'b0;
      exp_table     <= '0;
      exp_video     <= '0;
      prev_active   <= 1'b0;
      prev_hs       <= 1'b0;
      prev_vs       <= 1'b0;
      since_hs_rise = -1;
    end else begin
      // each field takes the low bits of a write to its own address
      if (bridge.wr) begin
        if (bridge.addr == settings_addr_hide_overscan) begin
          exp_settings.hide_overscan <= bridge.wr_data[0];
        end
        if (bridge.addr == settings_addr_mask_edges) begin
          exp_settings.mask_vid_edges <= bridge.wr_data[1:0];
        end
        if (bridge.addr == settings_addr_extra_sprites) begin
          exp_settings.allow_extra_sprites <= bridge.wr_data[0];
        end
        if (bridge.addr == settings_addr_palette) begin
          exp_settings.selected_palette <= bridge.wr_data[2:0];
        end
      end

      if (dataslot_requestwrite) begin
        exp_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        exp_download <= 1'b0;
      end

      // size entry of data slot index 1 sits at table word 3
      exp_table.wren <= 1'b1;
      exp_table.addr <= 10'd3;
      exp_table.data <= has_save ? save_size_bytes : 32'h0;

      model_active = !(video_in.hblank || video_in.vblank);
      model_slot = '0;
      model_slot[slot_overscan_bit] = exp_settings.hide_overscan;
      exp_video.de <= model_active;
      exp_video.vs <= video_in.vs && !prev_vs;
      if (model_active) begin
        exp_video.rgb <= video_in.rgb;
      end else if (prev_active) begin
        exp_video.rgb <= model_slot;
      end else begin
        exp_video.rgb <= '0;
      end

      // cycles since the last hs rise, pulse when it reaches the delay
      if (video_in.hs && !prev_hs) begin
        since_hs_rise = 0;
      end else if (since_hs_rise >= 0 && since_hs_rise < int'(hs_delay_cycles)) begin
        since_hs_rise = since_hs_rise + 1;
      end else begin
        since_hs_rise = -1;
      end
      exp_video.hs <= (since_hs_rise == int'(hs_delay_cycles));

      prev_active <= model_active;
      prev_hs     <= video_in.hs;
      prev_vs     <= video_in.vs;
    end
  end

  ////////////////////////////////////////////////////
  // output checks

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    error_count++;
    $display("Error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
  endtask

  check_settings: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settings == exp_settings)
    else report_mismatch("settings", $sampled(exp_settings), $sampled(settings));

  check_download: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    download == exp_download)
    else report_mismatch("download", $sampled(exp_download), $sampled(download));

  check_datatable: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable == exp_table)
    else report_mismatch("datatable", $sampled(exp_table), $sampled(datatable));

  check_de: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.de == exp_video.de)
    else report_mismatch("video_out.de", $sampled(exp_video.de), $sampled(video_out.de));

  check_rgb: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.rgb == exp_video.rgb)
    else report_mismatch("video_out.rgb", $sampled(exp_video.rgb), $sampled(video_out.rgb));

  check_hs: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs == exp_video.hs)
    else report_mismatch("video_out.hs", $sampled(exp_video.hs), $sampled(video_out.hs));

  check_vs: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.vs == exp_video.vs)
    else report_mismatch("video_out.vs", $sampled(exp_video.vs), $sampled(video_out.vs));

  ////////////////////////////////////////////////////
  // stimulus

  // settings writes, some to aliased or unrelated addresses
  task automatic write_settings_traffic(input int cycles);
    bridge_wr_t w;
    int         pick;
    for (int i = 0; i < cycles; i++) begin
      pick = $urandom % 6;
      w.wr = ($urandom % 4) != 0;
      case (pick)
        0: w.addr = settings_addr_hide_overscan;
        1: w.addr = settings_addr_mask_edges;
        2: w.addr = settings_addr_extra_sprites;
        3: w.addr = settings_addr_palette;
        4: w.addr = 32'h1000_0000 | settings_addr_mask_edges;
        default: w.addr = $urandom;
      endcase
      w.wr_data = $urandom;
      @(posedge clk_74a);
      bridge <= w;
    end
    @(posedge clk_74a);
    bridge <= '0;
  endtask

  // pick 7 raises request and complete together
  task automatic toggle_slot_strobes(input int cycles);
    int pick;
    for (int i = 0; i < cycles; i++) begin
      pick = $urandom % 8;
      @(posedge clk_74a);
      dataslot_requestwrite <= (pick == 0) || (pick == 7);
      dataslot_allcomplete  <= (pick == 1) || (pick == 2) || (pick == 7);
      if (($urandom % 16) == 0) begin
        has_save <= !has_save;
      end
    end
    @(posedge clk_74a);
    dataslot_requestwrite <= 1'b0;
    dataslot_allcomplete  <= 1'b0;
  endtask

  task automatic send_pixel(input logic hb, input logic vb, input logic hs, input logic vs);
    video_in_t pix;
    pix.hblank = hb;
    pix.vblank = vb;
    pix.hs     = hs;
    pix.vs     = vs;
    pix.rgb    = 24'($urandom);
    @(posedge clk_74a);
    video_in <= pix;
  endtask

  // 10 active lines then 4 vblank lines, vs high on lines 11 and 12
  task automatic send_raster(input int frames);
    int   act_w;
    int   hb_w;
    int   hs_start;
    logic double_hs;
    logic vb;
    logic vs_line;
    logic hs;
    for (int f = 0; f < frames; f++) begin
      for (int line = 0; line < 14; line++) begin
        vb        = (line >= 10);
        vs_line   = (line == 11) || (line == 12);
        act_w     = 16 + $urandom % 33;
        hb_w      = 8 + $urandom % 13;
        hs_start  = 1 + $urandom % 3;
        // second rise 3 cycles after the first restarts the delay
        double_hs = (line == 2) || (($urandom % 3) == 0);
        for (int x = 0; x < act_w; x++) begin
          send_pixel(1'b0, vb, 1'b0, vs_line);
        end
        for (int x = 0; x < hb_w; x++) begin
          hs = (x >= hs_start && x < hs_start + 2) || (double_hs && x == hs_start + 3);
          send_pixel(1'b1, vb, hs, vs_line);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // run control

  initial begin
    void'($urandom(52365));
    bridge                = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    has_save              = 1'b0;
    video_in              = '0;
    wait (pll_core_locked === 1'b1);
    @(posedge clk_74a);
    fork
      write_settings_traffic(600);
      toggle_slot_strobes(600);
      send_raster(2);
    join
    // long enough for a delayed hsync to come out
    repeat (12) @(posedge clk_74a);
    $display("run complete, error count %0d", error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
      $display("run stopped, error count %0d", error_count);
      $display("Errors found");
      $finish;
    end
  end

endmodule

/* sim/tb_clock.sv */
// clock and reset source for the testbench
// 100 ns clock period, reset held low for the first 3 rising edges

`timescale 1ns/1ps

module tb_clock (
  output logic clk_74a,
  output logic pll_core_locked
);

  // half period of 50 ns
  initial begin
    clk_74a = 1'b0;
    forever #50 clk_74a = ~clk_74a;
  end

  initial begin
    pll_core_locked = 1'b0;
    repeat (3) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
  end

endmodule

/* source/core_top.sv */
// glue between the host bridge, the nes core and the scaler
// single clock domain, video runs at one pixel per clk_74a
// core video, has_save and slot strobes arrive as plain inputs
// no back-pressure, every output is a level or a strobe

`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic           clk_74a,
  input  logic           pll_core_locked,

  // host bridge
  input  bridge_wr_t     bridge,
  output core_settings_t settings,

  // host data slot commands
  input  logic           dataslot_requestwrite,
  input  logic           dataslot_allcomplete,
  input  logic           has_save,
  output logic           download,
  output datatable_wr_t  datatable,

  // emulator video in, scaler video out
  input  video_in_t      video_in,
  output video_out_t     video_out
);

  core_settings_t settings_q;

  //////////////////////////////////////////////////
  // settings

  bridge_settings bridge_settings_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .settings        (settings_q)
  );

  assign settings = settings_q;

  //////////////////////////////////////////////////
  // data slots

  slot_status slot_status_inst (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .has_save              (has_save),
    .download              (download),
    .datatable             (datatable)
  );

  //////////////////////////////////////////////////
  // video

  // overscan flag rides in the slot word to the scaler
  video_conditioner video_conditioner_inst (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hide_overscan   (settings_q.hide_overscan),
    .video_in        (video_in),
    .video_out       (video_out)
  );

endmodule

/* source/video_conditioner.sv */
// conditions emulator video for the scaler
// all outputs registered, one cycle behind the sampled inputs
// syncs become single-cycle pulses, hsync delayed against vsync
// a slot word with the overscan flag follows each active line

`timescale 1ns/1ps

module video_conditioner import core_pkg::*; (
  input  logic       clk_74a,
  input  logic       pll_core_locked,
  input  logic       hide_overscan,
  input  video_in_t  video_in,
  output video_out_t video_out
);

  logic        active;
  logic        active_prev;
  logic        line_end;
  logic        hs_prev;
  logic        hs_rise;
  logic        vs_prev;
  logic        vs_rise;
  logic [2:0]  hs_delay;
  logic [23:0] slot_word;

  //////////////////////////////////////////////////
  // edge detect on the raw inputs

  assign active   = ~(video_in.hblank | video_in.vblank);
  assign line_end = active_prev & ~active;
  assign hs_rise  = video_in.hs & ~hs_prev;
  assign vs_rise  = video_in.vs & ~vs_prev;

  // only the overscan flag is carried, the rest stays zero
  assign slot_word = 24'(hide_overscan) << slot_overscan_bit;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      active_prev <= 1'b0;
      hs_prev     <= 1'b0;
      vs_prev     <= 1'b0;
    end else begin
      active_prev <= active;
      hs_prev     <= video_in.hs;
      vs_prev     <= video_in.vs;
    end
  end

  //////////////////////////////////////////////////
  // hsync delay

  // a new rise reloads, so the last rise sets the pulse time
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_delay <= '0;
    end else if (hs_rise) begin
      hs_delay <= hs_delay_cycles;
    end else if (hs_delay != '0) begin
      hs_delay <= hs_delay - 3'd1;
    end
  end

  //////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
    end else begin
      video_out.de <= active;
      video_out.vs <= vs_rise;
      // counter at one means seven edges since the rise
      video_out.hs <= (hs_delay == 3'd1);
      if (active) begin
        video_out.rgb <= video_in.rgb;
      end else if (line_end) begin
        video_out.rgb <= slot_word;
      end else begin
        video_out.rgb <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks

  a_hs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs |=> !video_out.hs
  ) else $error("hsync pulse longer than one cycle");

  a_vs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.vs |=> !video_out.vs
  ) else $error("vsync pulse longer than one cycle");

  // blank colour is zero except on the slot word cycle
  a_blank_black: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (!video_out.de && !$past(video_out.de)) |-> (video_out.rgb == '0)
  ) else $error("nonzero rgb during blanking");

endmodule

/* source/slot_status.sv */
// download flag and save-size report for the host data table
// strobes are single-cycle pulses from the host command side
// the size entry is rewritten every cycle, there is no handshake

`timescale 1ns/1ps

module slot_status import core_pkg::*; (
  input  logic          clk_74a,
  input  logic          pll_core_locked,
  input  logic          dataslot_requestwrite,
  input  logic          dataslot_allcomplete,
  input  logic          has_save,
  output logic          download,
  output datatable_wr_t datatable
);

  //////////////////////////////////////////////////
  // download level

  // request wins over complete in the same cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      download <= 1'b0;
    end else if (dataslot_requestwrite) begin
      download <= 1'b1;
    end else if (dataslot_allcomplete) begin
      download <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // save size entry

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable <= '0;
    end else begin
      datatable.wren <= 1'b1;
      datatable.addr <= save_table_addr;
      // zero size tells the host there is nothing to save
      if (has_save) begin
        datatable.data <= save_size_bytes;
      end else begin
        datatable.data <= '0;
      end
    end
  end

  a_download_held: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    dataslot_requestwrite |=> download
  ) else $error("download low after a requestwrite strobe");

endmodule

/* source/bridge_settings.sv */
// settings registers written by the host over the bridge
// only full 32-bit address matches are decoded, no byte enables
// reads are not served here, the host keeps its own copy
// unused upper data bits of each write are ignored

`timescale 1ns/1ps

module bridge_settings import core_pkg::*; (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  bridge_wr_t     bridge,
  output core_settings_t settings
);

  settings_reg_e reg_sel;
  logic          reg_hit;

  //////////////////////////////////////////////////
  // address decode

  always_comb begin
    reg_hit = 1'b1;
    reg_sel = reg_hide_overscan;
    case (bridge.addr)
      settings_addr_hide_overscan: reg_sel = reg_hide_overscan;
      settings_addr_mask_edges:    reg_sel = reg_mask_edges;
      settings_addr_extra_sprites: reg_sel = reg_extra_sprites;
      settings_addr_palette:       reg_sel = reg_palette;
      default:                     reg_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // register update

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge.wr && reg_hit) begin
      case (reg_sel)
        reg_hide_overscan: begin
          settings.hide_overscan <= bridge.wr_data[0];
        end
        reg_mask_edges: begin
          settings.mask_vid_edges <= bridge.wr_data[1:0];
        end
        reg_extra_sprites: begin
          settings.allow_extra_sprites <= bridge.wr_data[0];
        end
        reg_palette: begin
          settings.selected_palette <= bridge.wr_data[2:0];
        end
      endcase
    end
  end

  // palette only moves after a write to its own register
  a_palette_needs_write: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    $changed(settings.selected_palette) |->
      $past(bridge.wr && (bridge.addr == settings_addr_palette))
  ) else $error("selected_palette changed without a palette write");

endmodule

/* source/core_pkg.sv */
// shared types and constants for the nes bridge glue
// everything runs on clk_74a, video treated as one pixel per clock
// bridge addresses follow the host register map at 0x200..0x20c
// save size is fixed, the core only reports present or absent

package core_pkg;

  //////////////////////////////////////////////////
  // settings registers

  typedef enum logic [1:0] {
    reg_hide_overscan = 2'd0,
    reg_mask_edges    = 2'd1,
    reg_extra_sprites = 2'd2,
    reg_palette       = 2'd3
  } settings_reg_e;

  localparam logic [31:0] settings_addr_hide_overscan = 32'h0000_0200;
  localparam logic [31:0] settings_addr_mask_edges    = 32'h0000_0204;
  localparam logic [31:0] settings_addr_extra_sprites = 32'h0000_0208;
  localparam logic [31:0] settings_addr_palette       = 32'h0000_020c;

  typedef struct packed {
    logic       hide_overscan;
    logic [1:0] mask_vid_edges;
    logic       allow_extra_sprites;
    logic [2:0] selected_palette;
  } core_settings_t;

  // host bridge write side
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wr_data;
  } bridge_wr_t;

  //////////////////////////////////////////////////
  // data table

  typedef struct packed {
    logic        wren;
    logic [9:0]  addr;
    logic [31:0] data;
  } datatable_wr_t;

  // slot index, not slot id
  localparam int unsigned save_slot_index = 1;
  // each slot takes two table words, size is the second one
  localparam logic [9:0]  save_table_addr = 10'(save_slot_index * 2 + 1);
  localparam logic [31:0] save_size_bytes = 32'h0004_0000;

  //////////////////////////////////////////////////
  // video

  typedef struct packed {
    logic        hblank;
    logic        vblank;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_in_t;

  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_out_t;

  // keeps hsync clear of the vsync pulse
  localparam logic [2:0] hs_delay_cycles   = 3'd7;
  localparam int         slot_overscan_bit = 13;

endpackage
